// ==== hdl/fix_cfg_pkg.sv ====
package fix_cfg_pkg;

  // tick count used for both the heartbeat and the reconnect waits.
  typedef logic [7:0] interval_t;

  // protocol version code, zero-extended to a byte when it goes into a frame.
  typedef logic [5:0] begin_code_t;

  // connection role of this end of the session.
  typedef enum logic [1:0] {
    ROLE_INITIATOR = 2'd0,
    ROLE_ACCEPTOR  = 2'd1,
    ROLE_NONE      = 2'd2
  } conn_role_e;

  // session configuration as written by the host, 24 bits in total.
  typedef struct packed {
    conn_role_e  role;
    begin_code_t begin_code;
    interval_t   heartbeat_int;
    interval_t   reconnect_int;
  } session_cfg_t;

endpackage

// ==== hdl/fix_msg_pkg.sv ====
package fix_msg_pkg;

  // one byte of an outgoing frame.
  typedef logic [7:0] msg_byte_t;

  // session message sequence number.
  typedef logic [15:0] seq_num_t;

  // message types carry their ASCII codes from the FIX MsgType field.
  typedef enum logic [7:0] {
    MSG_HEARTBEAT = 8'h30,
    MSG_LOGOUT    = 8'h35,
    MSG_LOGON     = 8'h41
  } msg_type_e;

  // request from the session FSM to the frame serializer.
  typedef struct packed {
    msg_type_e msg_type;
    seq_num_t  seq;
  } msg_req_t;

endpackage

// ==== hdl/session_config.sv ====
module session_config #(
  parameter int ID_BYTES = 8,
  localparam int ID_WIDTH = 8 * ID_BYTES,
  localparam int LEN_WIDTH = $clog2(ID_BYTES + 1)
) (
  input  logic                       clk,
  input  logic                       rst_i,
  input  logic                       configure_i,
  input  fix_cfg_pkg::session_cfg_t  cfg_i,
  input  logic [ID_WIDTH-1:0]        sender_id_i,
  input  logic [ID_WIDTH-1:0]        target_id_i,
  input  logic [LEN_WIDTH-1:0]       sender_len_i,
  input  logic [LEN_WIDTH-1:0]       target_len_i,
  input  logic                       cfg_lock_i,
  output fix_cfg_pkg::session_cfg_t  cfg_o,
  output logic [ID_WIDTH-1:0]        sender_id_o,
  output logic [ID_WIDTH-1:0]        target_id_o,
  output logic [LEN_WIDTH-1:0]       sender_len_o,
  output logic [LEN_WIDTH-1:0]       target_len_o,
  output logic                       cfg_valid_o
);

  // first stage holds the raw host write while it is checked.
  fix_cfg_pkg::session_cfg_t cap_cfg_q;
  logic [ID_WIDTH-1:0]       cap_sender_q;
  logic [ID_WIDTH-1:0]       cap_target_q;
  logic [LEN_WIDTH-1:0]      cap_sender_len_q;
  logic [LEN_WIDTH-1:0]      cap_target_len_q;
  logic                      load_q;
  logic                      cfg_ok;

  always_comb begin
    cfg_ok = (cap_sender_len_q != '0) && (cap_sender_len_q <= ID_BYTES) &&
             (cap_target_len_q != '0) && (cap_target_len_q <= ID_BYTES) &&
             ((cap_cfg_q.role == fix_cfg_pkg::ROLE_INITIATOR) ||
              (cap_cfg_q.role == fix_cfg_pkg::ROLE_ACCEPTOR)) &&
             (cap_cfg_q.heartbeat_int != '0);
  end

  always_ff @(posedge clk) begin
    if (configure_i && !cfg_lock_i) begin
      cap_cfg_q        <= cfg_i;
      cap_sender_q     <= sender_id_i;
      cap_target_q     <= target_id_i;
      cap_sender_len_q <= sender_len_i;
      cap_target_len_q <= target_len_i;
    end
    if (load_q) begin
      cfg_o        <= cap_cfg_q;
      sender_id_o  <= cap_sender_q;
      target_id_o  <= cap_target_q;
      sender_len_o <= cap_sender_len_q;
      target_len_o <= cap_target_len_q;
    end
  end

  // the old configuration is withdrawn as soon as a new write is taken.
  always_ff @(posedge clk) begin
    if (rst_i) begin
      load_q      <= 1'b0;
      cfg_valid_o <= 1'b0;
    end else begin
      load_q <= configure_i && !cfg_lock_i;
      if (configure_i && !cfg_lock_i) begin
        cfg_valid_o <= 1'b0;
      end else if (load_q) begin
        cfg_valid_o <= cfg_ok;
      end
    end
  end

  a_valid_lengths: assert property (@(posedge clk) disable iff (rst_i)
    cfg_valid_o |-> (sender_len_o != '0) && (sender_len_o <= ID_BYTES) &&
                    (target_len_o != '0) && (target_len_o <= ID_BYTES));

endmodule

// ==== hdl/session_fsm.sv ====
module session_fsm (
  input  logic                      clk,
  input  logic                      rst_i,
  input  fix_cfg_pkg::session_cfg_t cfg_i,
  input  logic                      cfg_valid_i,
  input  logic                      connect_i,
  input  logic                      peer_logon_i,
  input  logic                      tick_i,
  input  logic                      busy_i,
  output logic                      req_valid_o,
  output fix_msg_pkg::msg_req_t     req_o,
  output logic                      session_active_o,
  output logic                      cfg_lock_o
);

  typedef enum logic [1:0] {
    IDLE,
    WAIT_PEER,
    ACTIVE,
    HOLDOFF
  } state_e;

  state_e                    state_q;
  state_e                    state_d;
  fix_cfg_pkg::interval_t    cnt_q;
  fix_cfg_pkg::interval_t    cnt_d;
  fix_msg_pkg::seq_num_t     seq_q;
  fix_msg_pkg::seq_num_t     req_seq;
  logic                      pend_q;
  fix_msg_pkg::msg_type_e    pend_type_q;
  logic                      ev_valid;
  fix_msg_pkg::msg_type_e    ev_type;
  logic                      can_issue;
  fix_msg_pkg::msg_type_e    out_type;

  // one request may wait for the serializer, so new events stay off until it is gone.
  always_comb begin
    state_d  = state_q;
    cnt_d    = cnt_q;
    ev_valid = 1'b0;
    ev_type  = fix_msg_pkg::MSG_HEARTBEAT;
    case (state_q)
      IDLE: begin
        if (cfg_valid_i && connect_i) begin
          if (cfg_i.role == fix_cfg_pkg::ROLE_INITIATOR) begin
            ev_valid = 1'b1;
            ev_type  = fix_msg_pkg::MSG_LOGON;
            cnt_d    = '0;
            state_d  = ACTIVE;
          end else begin
            state_d = WAIT_PEER;
          end
        end
      end
      WAIT_PEER: begin
        if (!cfg_valid_i || !connect_i) begin
          state_d = IDLE;
        end else if (peer_logon_i) begin
          ev_valid = 1'b1;
          ev_type  = fix_msg_pkg::MSG_LOGON;
          cnt_d    = '0;
          state_d  = ACTIVE;
        end
      end
      ACTIVE: begin
        if (pend_q) begin
          state_d = ACTIVE;
        end else if (!connect_i) begin
          ev_valid = 1'b1;
          ev_type  = fix_msg_pkg::MSG_LOGOUT;
          cnt_d    = '0;
          state_d  = HOLDOFF;
        end else if (tick_i) begin
          if (fix_cfg_pkg::interval_t'(cnt_q + 1'b1) == cfg_i.heartbeat_int) begin
            ev_valid = 1'b1;
            ev_type  = fix_msg_pkg::MSG_HEARTBEAT;
            cnt_d    = '0;
          end else begin
            cnt_d = cnt_q + 1'b1;
          end
        end
      end
      HOLDOFF: begin
        // the logout has to be handed over before a new logon can follow.
        if ((cnt_q == cfg_i.reconnect_int) && !pend_q) begin
          state_d = IDLE;
        end else if (tick_i && (cnt_q != cfg_i.reconnect_int)) begin
          cnt_d = cnt_q + 1'b1;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  assign can_issue = !busy_i && !req_valid_o;
  assign out_type  = pend_q ? pend_type_q : ev_type;
  assign req_seq   = (out_type == fix_msg_pkg::MSG_LOGON) ? 16'd1 : seq_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q     <= IDLE;
      cnt_q       <= '0;
      seq_q       <= 16'd1;
      pend_q      <= 1'b0;
      req_valid_o <= 1'b0;
    end else begin
      state_q     <= state_d;
      cnt_q       <= cnt_d;
      req_valid_o <= 1'b0;
      if ((ev_valid || pend_q) && can_issue) begin
        req_valid_o <= 1'b1;
        seq_q       <= req_seq + 1'b1;
        pend_q      <= 1'b0;
      end else if (ev_valid) begin
        pend_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ev_valid) begin
      pend_type_q <= ev_type;
    end
    if ((ev_valid || pend_q) && can_issue) begin
      req_o.msg_type <= out_type;
      req_o.seq      <= req_seq;
    end
  end

  assign session_active_o = (state_q == ACTIVE);
  assign cfg_lock_o       = (state_q == ACTIVE) || (state_q == HOLDOFF);

  a_no_req_when_busy: assert property (@(posedge clk) disable iff (rst_i)
    req_valid_o |-> !busy_i);

endmodule

// ==== hdl/msg_serializer.sv ====
module msg_serializer #(
  parameter int ID_BYTES = 8,
  localparam int ID_WIDTH = 8 * ID_BYTES,
  localparam int LEN_WIDTH = $clog2(ID_BYTES + 1)
) (
  input  logic                     clk,
  input  logic                     rst_i,
  input  logic                     req_valid_i,
  input  fix_msg_pkg::msg_req_t    req_i,
  input  fix_cfg_pkg::begin_code_t begin_code_i,
  input  fix_cfg_pkg::interval_t   heartbeat_int_i,
  input  logic [ID_WIDTH-1:0]      sender_id_i,
  input  logic [ID_WIDTH-1:0]      target_id_i,
  input  logic [LEN_WIDTH-1:0]     sender_len_i,
  input  logic [LEN_WIDTH-1:0]     target_len_i,
  output logic                     busy_o,
  output logic                     byte_valid_o,
  output fix_msg_pkg::msg_byte_t   byte_o,
  output logic                     byte_last_o
);

  // fields in the order they appear on the wire.
  typedef enum logic [2:0] {
    FLD_BEGIN,
    FLD_TYPE,
    FLD_SEQ_HI,
    FLD_SEQ_LO,
    FLD_SENDER,
    FLD_TARGET,
    FLD_HB,
    FLD_CSUM
  } field_e;

  field_e                 field_q;
  logic [LEN_WIDTH-1:0]   pos_q;
  fix_msg_pkg::msg_req_t  req_q;
  fix_msg_pkg::msg_byte_t sum_q;
  fix_msg_pkg::msg_byte_t cur_byte;

  always_comb begin
    case (field_q)
      FLD_BEGIN:  cur_byte = {2'b00, begin_code_i};
      FLD_TYPE:   cur_byte = req_q.msg_type;
      FLD_SEQ_HI: cur_byte = req_q.seq[15:8];
      FLD_SEQ_LO: cur_byte = req_q.seq[7:0];
      FLD_SENDER: cur_byte = sender_id_i[8 * pos_q +: 8];
      FLD_TARGET: cur_byte = target_id_i[8 * pos_q +: 8];
      FLD_HB:     cur_byte = heartbeat_int_i;
      default:    cur_byte = sum_q;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      busy_o       <= 1'b0;
      byte_valid_o <= 1'b0;
      byte_last_o  <= 1'b0;
      field_q      <= FLD_BEGIN;
      pos_q        <= '0;
    end else begin
      byte_valid_o <= 1'b0;
      byte_last_o  <= 1'b0;
      if (!busy_o) begin
        if (req_valid_i) begin
          busy_o  <= 1'b1;
          field_q <= FLD_BEGIN;
          pos_q   <= '0;
        end
      end else if (byte_last_o) begin
        // the checksum went out last cycle, so the frame is complete.
        busy_o <= 1'b0;
      end else begin
        byte_valid_o <= 1'b1;
        case (field_q)
          FLD_BEGIN:  field_q <= FLD_TYPE;
          FLD_TYPE:   field_q <= FLD_SEQ_HI;
          FLD_SEQ_HI: field_q <= FLD_SEQ_LO;
          FLD_SEQ_LO: field_q <= FLD_SENDER;
          FLD_SENDER: begin
            if (pos_q == LEN_WIDTH'(sender_len_i - 1'b1)) begin
              field_q <= FLD_TARGET;
              pos_q   <= '0;
            end else begin
              pos_q <= pos_q + 1'b1;
            end
          end
          FLD_TARGET: begin
            if (pos_q == LEN_WIDTH'(target_len_i - 1'b1)) begin
              field_q <= FLD_HB;
              pos_q   <= '0;
            end else begin
              pos_q <= pos_q + 1'b1;
            end
          end
          FLD_HB:     field_q <= FLD_CSUM;
          default:    byte_last_o <= 1'b1;
        endcase
      end
    end
  end

  // request, output byte and checksum accumulator.
  always_ff @(posedge clk) begin
    if (!busy_o && req_valid_i) begin
      req_q <= req_i;
      sum_q <= '0;
    end else if (busy_o && !byte_last_o) begin
      byte_o <= cur_byte;
      sum_q  <= sum_q + cur_byte;
    end
  end

  a_last_is_valid: assert property (@(posedge clk) disable iff (rst_i)
    byte_last_o |-> byte_valid_o);

  a_valid_when_busy: assert property (@(posedge clk) disable iff (rst_i)
    byte_valid_o |-> busy_o);

endmodule

// ==== hdl/fix_session_top.sv ====
module fix_session_top #(
  parameter int ID_BYTES = 8,
  localparam int ID_WIDTH = 8 * ID_BYTES,
  localparam int LEN_WIDTH = $clog2(ID_BYTES + 1)
) (
  input  logic                      clk,
  input  logic                      rst_i,
  input  logic                      configure_i,
  input  fix_cfg_pkg::session_cfg_t cfg_i,
  input  logic [ID_WIDTH-1:0]       sender_id_i,
  input  logic [ID_WIDTH-1:0]       target_id_i,
  input  logic [LEN_WIDTH-1:0]      sender_len_i,
  input  logic [LEN_WIDTH-1:0]      target_len_i,
  input  logic                      connect_i,
  input  logic                      peer_logon_i,
  input  logic                      tick_i,
  output logic                      byte_valid_o,
  output fix_msg_pkg::msg_byte_t    byte_o,
  output logic                      byte_last_o,
  output logic                      session_active_o,
  output logic                      cfg_valid_o
);

  fix_cfg_pkg::session_cfg_t cfg;
  logic [ID_WIDTH-1:0]       sender_id;
  logic [ID_WIDTH-1:0]       target_id;
  logic [LEN_WIDTH-1:0]      sender_len;
  logic [LEN_WIDTH-1:0]      target_len;
  logic                      cfg_lock;
  logic                      req_valid;
  fix_msg_pkg::msg_req_t     req;
  logic                      busy;

  session_config #(.ID_BYTES(ID_BYTES)) session_config_i (
    .clk, .rst_i, .configure_i, .cfg_i, .sender_id_i, .target_id_i,
    .sender_len_i, .target_len_i,
    .cfg_lock_i(cfg_lock), .cfg_o(cfg), .sender_id_o(sender_id),
    .target_id_o(target_id), .sender_len_o(sender_len),
    .target_len_o(target_len), .cfg_valid_o
  );

  session_fsm session_fsm_i (
    .clk, .rst_i, .cfg_i(cfg), .cfg_valid_i(cfg_valid_o), .connect_i,
    .peer_logon_i, .tick_i, .busy_i(busy), .req_valid_o(req_valid),
    .req_o(req), .session_active_o, .cfg_lock_o(cfg_lock)
  );

  msg_serializer #(.ID_BYTES(ID_BYTES)) msg_serializer_i (
    .clk, .rst_i, .req_valid_i(req_valid), .req_i(req),
    .begin_code_i(cfg.begin_code), .heartbeat_int_i(cfg.heartbeat_int),
    .sender_id_i(sender_id), .target_id_i(target_id),
    .sender_len_i(sender_len), .target_len_i(target_len),
    .busy_o(busy), .byte_valid_o, .byte_o, .byte_last_o
  );

endmodule

// ==== bench/fix_session_tb.sv ====
module fix_session_tb;

  localparam int ID_BYTES = 8;
  localparam int ID_WIDTH = 8 * ID_BYTES;
  localparam int LEN_WIDTH = $clog2(ID_BYTES + 1);
  localparam int NUM_SESSIONS = 6;

  // worst case per session: five frames, three runs of up to eight ticks, some idle time.
  localparam int FRAME_CYCLES = 6 + 2 * ID_BYTES + 4;
  localparam int TICK_CYCLES = 2 * 8;
  localparam int SESSION_CYCLES = 5 * FRAME_CYCLES + 3 * TICK_CYCLES + 60;
  localparam int WATCHDOG_CYCLES = 2 * (NUM_SESSIONS * SESSION_CYCLES + 3 * 20 + 20);

  logic                      clk;
  logic                      rst_i;
  logic                      configure_i;
  fix_cfg_pkg::session_cfg_t cfg_i;
  logic [ID_WIDTH-1:0]       sender_id_i;
  logic [ID_WIDTH-1:0]       target_id_i;
  logic [LEN_WIDTH-1:0]      sender_len_i;
  logic [LEN_WIDTH-1:0]      target_len_i;
  logic                      connect_i;
  logic                      peer_logon_i;
  logic                      tick_i;
  logic                      byte_valid_o;
  fix_msg_pkg::msg_byte_t    byte_o;
  logic                      byte_last_o;
  logic                      session_active_o;
  logic                      cfg_valid_o;

  logic [31:0]               lfsr_q;
  fix_msg_pkg::msg_req_t     exp_q[$];
  fix_msg_pkg::msg_byte_t    got_q[$];
  fix_msg_pkg::msg_byte_t    ref_q[$];

  fix_session_top #(.ID_BYTES(ID_BYTES)) fix_session_top_i (
    .clk, .rst_i, .configure_i, .cfg_i, .sender_id_i, .target_id_i,
    .sender_len_i, .target_len_i, .connect_i, .peer_logon_i, .tick_i,
    .byte_valid_o, .byte_o, .byte_last_o, .session_active_o, .cfg_valid_o
  );

  always #10 clk = ~clk;

  // taps 32, 22, 2 and 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [63:0] v);
    v = '0;
    repeat (n) begin
      v = {v[62:0], lfsr_q[31]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  task automatic stop_run();
    $display("Testbench failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("FAIL at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
      stop_run();
    end
  endtask

  // expected frame from the configuration currently driven into the DUT.
  function automatic void build_frame(input fix_msg_pkg::msg_req_t req);
    int i;
    fix_msg_pkg::msg_byte_t sum;
    ref_q.delete();
    ref_q.push_back({2'b00, cfg_i.begin_code});
    ref_q.push_back(req.msg_type);
    ref_q.push_back(req.seq[15:8]);
    ref_q.push_back(req.seq[7:0]);
    for (i = 0; i < int'(sender_len_i); i++) begin
      ref_q.push_back(sender_id_i[8 * i +: 8]);
    end
    for (i = 0; i < int'(target_len_i); i++) begin
      ref_q.push_back(target_id_i[8 * i +: 8]);
    end
    ref_q.push_back(cfg_i.heartbeat_int);
    sum = '0;
    foreach (ref_q[j]) begin
      sum = sum + ref_q[j];
    end
    ref_q.push_back(sum);
  endfunction

  task automatic compare_frame();
    int i;
    build_frame(exp_q.pop_front());
    check_equal(got_q.size(), ref_q.size(), "frame length");
    for (i = 0; i < ref_q.size(); i++) begin
      check_equal(got_q[i], ref_q[i], $sformatf("frame byte %0d", i));
    end
    got_q.delete();
  endtask

  // outputs change on the rising edge, so they are collected on the falling one.
  always @(negedge clk) begin
    if (byte_valid_o) begin
      if (got_q.size() == 0 && exp_q.size() == 0) begin
        $display("%0t: frame bytes appeared while no message was expected", $time);
        stop_run();
      end else begin
        got_q.push_back(byte_o);
        if (byte_last_o) begin
          compare_frame();
        end
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("%0t: watchdog expired after %0d cycles, the run is stuck", $time,
             WATCHDOG_CYCLES);
    stop_run();
  end

  task automatic step(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic pulse_tick();
    tick_i = 1'b1;
    step(1);
    tick_i = 1'b0;
    step(1);
  endtask

  task automatic expect_msg(input fix_msg_pkg::msg_type_e msg_type,
                            input fix_msg_pkg::seq_num_t seq);
    fix_msg_pkg::msg_req_t r;
    r.msg_type = msg_type;
    r.seq      = seq;
    exp_q.push_back(r);
  endtask

  task automatic wait_frames();
    while (exp_q.size() != 0) @(posedge clk);
    step(2);
  endtask

  task automatic configure(input logic expect_valid);
    configure_i = 1'b1;
    step(1);
    configure_i = 1'b0;
    check_equal(cfg_valid_o, 1'b0, "cfg_valid_o one cycle after configure_i");
    step(1);
    check_equal(cfg_valid_o, expect_valid, "cfg_valid_o two cycles after configure_i");
  endtask

  task automatic randomize_config(input bit acc);
    logic [63:0] v;
    int b;
    take_bits(6, v);
    cfg_i.begin_code = v[5:0];
    take_bits(3, v);
    cfg_i.heartbeat_int = fix_cfg_pkg::interval_t'(v[2:0]) + 8'd1;
    take_bits(3, v);
    cfg_i.reconnect_int = fix_cfg_pkg::interval_t'(v[2:0]) + 8'd1;
    take_bits(8, v);
    sender_len_i = LEN_WIDTH'(int'(v[7:0]) % ID_BYTES + 1);
    take_bits(8, v);
    target_len_i = LEN_WIDTH'(int'(v[7:0]) % ID_BYTES + 1);
    for (b = 0; b < ID_BYTES; b++) begin
      take_bits(8, v);
      sender_id_i[8 * b +: 8] = v[7:0];
      take_bits(8, v);
      target_id_i[8 * b +: 8] = v[7:0];
    end
    if (acc) begin
      cfg_i.role = fix_cfg_pkg::ROLE_ACCEPTOR;
    end else begin
      cfg_i.role = fix_cfg_pkg::ROLE_INITIATOR;
    end
  endtask

  // an acceptor stays silent until the peer's logon is signalled.
  task automatic accept_logon();
    step(8);
    expect_msg(fix_msg_pkg::MSG_LOGON, 16'd1);
    peer_logon_i = 1'b1;
    step(1);
    peer_logon_i = 1'b0;
  endtask

  task automatic run_session(input bit acc);
    if (!acc) begin
      expect_msg(fix_msg_pkg::MSG_LOGON, 16'd1);
    end
    connect_i = 1'b1;
    if (acc) begin
      accept_logon();
    end
    wait_frames();
    check_equal(session_active_o, 1'b1, "session_active_o after logon");
    // the heartbeat falls due on the last tick of the interval and not one tick sooner.
    repeat (int'(cfg_i.heartbeat_int) - 1) pulse_tick();
    step(8);
    expect_msg(fix_msg_pkg::MSG_HEARTBEAT, 16'd2);
    pulse_tick();
    wait_frames();
    expect_msg(fix_msg_pkg::MSG_LOGOUT, 16'd3);
    connect_i = 1'b0;
    wait_frames();
    check_equal(session_active_o, 1'b0, "session_active_o after logout");
    // connect_i returns at once, yet the next logon waits out the reconnect interval.
    connect_i = 1'b1;
    repeat (int'(cfg_i.reconnect_int) - 1) pulse_tick();
    step(8);
    if (!acc) begin
      expect_msg(fix_msg_pkg::MSG_LOGON, 16'd1);
    end
    pulse_tick();
    if (acc) begin
      accept_logon();
    end
    wait_frames();
    expect_msg(fix_msg_pkg::MSG_LOGOUT, 16'd2);
    connect_i = 1'b0;
    wait_frames();
    repeat (int'(cfg_i.reconnect_int)) pulse_tick();
    step(4);
  endtask

  initial begin
    int s;
    int k;
    clk          = 1'b0;
    rst_i        = 1'b1;
    configure_i  = 1'b0;
    cfg_i        = '0;
    sender_id_i  = '0;
    target_id_i  = '0;
    sender_len_i = '0;
    target_len_i = '0;
    connect_i    = 1'b0;
    peer_logon_i = 1'b0;
    tick_i       = 1'b0;
    lfsr_q       = 32'hd7e546b2;
    repeat (10) @(posedge clk);
    #2;
    rst_i = 1'b0;
    step(2);
    check_equal(cfg_valid_o, 1'b0, "cfg_valid_o after reset");

    // each broken configuration must keep the session silent.
    for (k = 0; k < 3; k++) begin
      randomize_config(1'b0);
      case (k)
        0:       sender_len_i = '0;
        1:       target_len_i = LEN_WIDTH'(ID_BYTES + 1);
        default: cfg_i.heartbeat_int = '0;
      endcase
      configure(1'b0);
      connect_i = 1'b1;
      step(12);
      connect_i = 1'b0;
      step(2);
    end

    for (s = 0; s < NUM_SESSIONS; s++) begin
      randomize_config(s == 1);
      configure(1'b1);
      run_session(s == 1);
    end

    if (exp_q.size() != 0 || got_q.size() != 0) begin
      $display("%0t: frames still outstanding at the end of the run", $time);
      stop_run();
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

// ==== src.f ====
hdl/fix_cfg_pkg.sv
hdl/fix_msg_pkg.sv
hdl/session_config.sv
hdl/session_fsm.sv
hdl/msg_serializer.sv
hdl/fix_session_top.sv
bench/fix_session_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fix_session_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	-./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "Testbench passed" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
